/* vlog.f */
src/rip_const.sv
src/rip_sram.sv
src/rip_mmu.sv
src/rip_pseudo_core.sv
src/rip_walk_top.sv
tb/tb_walk.sv

/* run.sh */
#!/bin/sh
# build and run the memory-walk testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_walk -f vlog.f -o Vtb_walk

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/Vtb_walk > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

/* tb/tb_walk.sv */
module tb_walk;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DATA_LEN     = 16;
    localparam int          MEM_WORDS    = 64;
    localparam int          WAIT_STATES  = 2;
    localparam int          BUSY_TIMEOUT = 50;     // cycles
    localparam int          WALK_TIMEOUT = 2000;
    localparam logic [31:0] NO_HEAD      = '1;
    localparam logic [31:0] INIT_PATTERN = 32'hc0de0000;

    logic                             clk;
    logic                             rstn;
    logic [rip_const::ADDR_WIDTH-1:0] mem_head;
    rip_const::core_status_e          status;
    rip_const::mem_req_s              dbg_req;
    rip_const::mem_resp_s             dbg_resp;

    rip_const::mem_word_u model [MEM_WORDS];    // expected memory contents

    rip_walk_top #(
        .DATA_LEN(DATA_LEN), .MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES)
    ) dut (
        .clk(clk), .rstn(rstn), .mem_head(mem_head), .status(status),
        .dbg_req(dbg_req), .dbg_resp(dbg_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reporting and checks
    // ------------------------------------------------------------------------
    task automatic stop_run(input string what);
        $display("[ERROR] t=%0t %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // debug port tasks start and end on a falling edge
    // ------------------------------------------------------------------------
    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (dbg_resp.busy !== level) begin
            n++;
            if (n > BUSY_TIMEOUT) stop_run({"timeout on busy during ", what});
            @(negedge clk);
        end
    endtask

    task automatic dbg_read(input int idx, output logic [31:0] data);
        dbg_req.re   = 1'b1;
        dbg_req.we   = '0;
        dbg_req.addr = 32'(idx) << 2;
        wait_busy(1'b1, "debug read");
        dbg_req.re = 1'b0;                  // drop the request once accepted
        wait_busy(1'b0, "debug read");
        data = dbg_resp.dout.word;
    endtask

    task automatic dbg_write(input int idx, input logic [3:0] mask, input logic [31:0] data);
        dbg_req.re       = 1'b0;
        dbg_req.we       = mask;
        dbg_req.addr     = 32'(idx) << 2;
        dbg_req.din.word = data;
        wait_busy(1'b1, "debug write");
        dbg_req.we = '0;
        wait_busy(1'b0, "debug write");
    endtask

    task automatic check_mem_word(input int idx);
        logic [31:0] got;
        dbg_read(idx, got);
        check_value($sformatf("mem[%0d]", idx), got, model[idx].word);
    endtask

    // hold head until the core is reading, then wait for idle
    task automatic start_walk(input logic [31:0] head, output bit saw_wr);
        int n;
        saw_wr   = 1'b0;
        mem_head = head;
        n        = 0;
        @(negedge clk);
        while (status != rip_const::reading) begin
            n++;
            if (n > BUSY_TIMEOUT) stop_run("walk never reached the reading state");
            @(negedge clk);
        end
        mem_head = NO_HEAD;                 // no restart after the last word
        n        = 0;
        while (status != rip_const::idle) begin
            if (status == rip_const::writing) saw_wr = 1'b1;
            n++;
            if (n > WALK_TIMEOUT) stop_run("walk did not return to idle");
            @(negedge clk);
        end
    endtask

    task automatic run_walk(input int first_word);
        bit saw_wr;
        start_walk(32'(first_word) << 2, saw_wr);
        check_value("saw writing", 32'(saw_wr), 32'd1);
        for (int i = first_word; i < first_word + DATA_LEN; i++) begin
            model[i].word = model[i].word + 32'd1;
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        check_value("status", 32'(status), 32'(rip_const::idle));
        check_value("dbg_resp.busy", 32'(dbg_resp.busy), 32'd0);
    endtask

    task automatic test_init_reads();
        int          idx;
        logic [31:0] got;
        repeat (8) begin
            idx = $urandom_range(MEM_WORDS - 1);
            dbg_read(idx, got);
            check_value($sformatf("mem[%0d]", idx), got, 32'(idx) ^ INIT_PATTERN);
        end
    endtask

    task automatic test_byte_write();
        int                   idx;
        logic [3:0]           mask;
        logic [31:0]          got;
        rip_const::mem_word_u wdata;
        rip_const::mem_word_u exp;
        idx        = $urandom_range(MEM_WORDS - 1);
        mask       = 4'($urandom_range(15, 1));
        wdata.word = $urandom();
        exp        = model[idx];
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) exp.bytes[b] = wdata.bytes[b];
        end
        dbg_write(idx, mask, wdata.word);
        dbg_read(idx, got);
        check_value($sformatf("mem[%0d] after byte write", idx), got, exp.word);
        dbg_write(idx, 4'hf, model[idx].word);   // put the old word back
        check_mem_word(idx);
    endtask

    task automatic test_walk_low();
        run_walk(0);
        for (int i = 0; i < 20; i++) check_mem_word(i);
    endtask

    task automatic test_walk_high();
        run_walk(16);
        for (int i = 0; i < 36; i++) check_mem_word(i);
    endtask

    // head present for a single cycle must not start a walk
    task automatic test_short_head();
        mem_head = 32'd128;
        @(negedge clk);
        mem_head = NO_HEAD;
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            assert (status == rip_const::idle || status == rip_const::init) else
                stop_run("walk started from a head held for one cycle");
        end
        check_value("status", 32'(status), 32'(rip_const::idle));
        for (int i = 32; i < 36; i++) check_mem_word(i);
        check_mem_word(0);
        check_mem_word(16);
    endtask

    initial begin
        void'($urandom(32'h2ac7717c));
        rstn     = 1'b0;
        mem_head = NO_HEAD;
        dbg_req  = '0;
        for (int i = 0; i < MEM_WORDS; i++) model[i].word = 32'(i) ^ INIT_PATTERN;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        test_reset();
        test_init_reads();
        test_byte_write();
        test_walk_low();
        test_walk_high();
        test_short_head();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* src/rip_walk_top.sv */
module rip_walk_top #(
    parameter int DATA_LEN    = 16,
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_STATES = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [rip_const::ADDR_WIDTH-1:0] mem_head,
    output rip_const::core_status_e         status,
    input  rip_const::mem_req_s             dbg_req,
    output rip_const::mem_resp_s            dbg_resp
);
    rip_const::mem_req_s              core_req;
    rip_const::mem_resp_s             core_resp;
    logic                             mem_stb;
    logic [rip_const::BYTES-1:0]      mem_we;
    logic [rip_const::ADDR_WIDTH-1:0] mem_addr;
    rip_const::mem_word_u             mem_wdata;
    rip_const::mem_word_u             mem_rdata;
    logic                             mem_done;

    rip_pseudo_core #(.DATA_LEN(DATA_LEN)) core (
        .clk(clk), .rstn(rstn), .mem_head(mem_head),
        .status(status), .req(core_req), .resp(core_resp)
    );

    // port 1 core, port 2 debug
    rip_mmu #(.WAIT_STATES(WAIT_STATES)) mmu (
        .clk(clk), .rstn(rstn),
        .req_1(core_req), .req_2(dbg_req),
        .resp_1(core_resp), .resp_2(dbg_resp),
        .mem_stb(mem_stb), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_done(mem_done)
    );

    rip_sram #(.MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES)) sram (
        .clk(clk), .rstn(rstn),
        .stb(mem_stb), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata), .done(mem_done)
    );

endmodule

/* src/rip_pseudo_core.sv */
module rip_pseudo_core #(
    parameter int DATA_LEN = 16
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [rip_const::ADDR_WIDTH-1:0] mem_head,
    output rip_const::core_status_e         status,
    output rip_const::mem_req_s             req,
    input  rip_const::mem_resp_s            resp
);
    localparam int unsigned AW = rip_const::ADDR_WIDTH;

    typedef enum logic [2:0] {
        st_sleep,
        st_init,
        st_read,
        st_readwait,
        st_write,
        st_writewait
    } state_e;

    state_e        state;
    logic [AW-1:0] mem_offset;    // latched walk base
    logic [AW-1:0] cnt;           // words done
    logic [AW-1:0] addr;
    logic          more;

    assign addr = mem_offset | (cnt << 2);
    assign more = cnt < AW'(DATA_LEN);

    always_comb begin
        case (state)
            st_sleep:                  status = rip_const::idle;
            st_read, st_readwait:      status = rip_const::reading;
            st_write, st_writewait:    status = rip_const::writing;
            default:                   status = rip_const::init;
        endcase
    end

    // ------------------------------------------------------------------------
    // walk FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= st_sleep;
            mem_offset <= '0;
            cnt        <= '0;
            req        <= '0;
        end else begin
            case (state)
                st_sleep: begin
                    if (mem_head != '1) begin
                        mem_offset <= mem_head;
                        cnt        <= '0;
                        state      <= st_init;
                    end
                end
                st_init: begin
                    // head must be stable for a cycle before the walk starts
                    if (mem_offset == mem_head) begin
                        req.addr <= addr;
                        req.re   <= 1'b1;
                        state    <= st_read;
                    end else begin
                        state <= st_sleep;
                    end
                end
                st_read: begin
                    if (!resp.busy) begin   // accepted at this edge
                        req.re <= 1'b0;
                        state  <= st_readwait;
                    end
                end
                st_readwait: begin
                    if (!resp.busy) begin
                        req.din.word <= resp.dout.word + 1'b1;
                        req.we       <= '1;
                        state        <= st_write;
                    end
                end
                st_write: begin
                    if (!resp.busy) begin
                        req.we <= '0;
                        cnt    <= cnt + 1'b1;
                        state  <= st_writewait;
                    end
                end
                st_writewait: begin
                    if (!resp.busy) begin
                        if (more) begin
                            req.addr <= addr;
                            req.re   <= 1'b1;
                            state    <= st_read;
                        end else begin
                            state <= st_sleep;
                        end
                    end
                end
                default: state <= st_sleep;
            endcase
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(req.re && |req.we))
        else $error("core requests read and write at once");

endmodule

/* src/rip_mmu.sv */
module rip_mmu #(
    parameter int WAIT_STATES = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  rip_const::mem_req_s             req_1,
    input  rip_const::mem_req_s             req_2,
    output rip_const::mem_resp_s            resp_1,
    output rip_const::mem_resp_s            resp_2,
    output logic                            mem_stb,
    output logic [rip_const::BYTES-1:0]     mem_we,
    output logic [rip_const::ADDR_WIDTH-1:0] mem_addr,
    output rip_const::mem_word_u            mem_wdata,
    input  rip_const::mem_word_u            mem_rdata,
    input  logic                            mem_done
);
    logic                 valid_1;
    logic                 valid_2;
    logic                 accept;
    logic                 busy;
    logic                 sel_2;     // port 2 owns the current transaction
    logic                 rd;        // current transaction is a read
    rip_const::mem_req_s  win;
    rip_const::mem_word_u dout_1;
    rip_const::mem_word_u dout_2;

    assign valid_1 = req_1.re | (|req_1.we);
    assign valid_2 = req_2.re | (|req_2.we);
    assign win     = valid_1 ? req_1 : req_2;    // port 1 has priority
    assign accept  = !busy && (valid_1 || valid_2);

    assign resp_1.busy = busy;
    assign resp_1.dout = dout_1;
    assign resp_2.busy = busy;
    assign resp_2.dout = dout_2;

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            mem_stb <= 1'b0;
            mem_we  <= '0;
            sel_2   <= 1'b0;
            rd      <= 1'b0;
        end else if (accept) begin
            busy    <= 1'b1;
            mem_stb <= 1'b1;                // single cycle
            mem_we  <= win.we;
            sel_2   <= !valid_1;
            rd      <= win.re;
        end else if (busy) begin
            mem_stb <= 1'b0;
            if (mem_done) begin
                busy   <= 1'b0;
                mem_we <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_addr  <= win.addr;
            mem_wdata <= win.din;
        end
    end

    // read data goes back to whichever port won
    always_ff @(posedge clk) begin
        if (busy && mem_done && rd) begin
            if (sel_2) begin
                dout_2 <= mem_rdata;
            end else begin
                dout_1 <= mem_rdata;
            end
        end
    end

    a_done_after_stb: assert property (@(posedge clk) disable iff (!rstn)
        mem_done |-> busy && $past(mem_stb, WAIT_STATES + 1))
        else $error("memory done without a matching strobe");

    a_busy_accepted: assert property (@(posedge clk) disable iff (!rstn)
        $rose(busy) |-> $past(valid_1 || valid_2))
        else $error("busy raised with no request pending");

endmodule

/* src/rip_sram.sv */
module rip_sram #(
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_STATES = 2
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            stb,
    input  logic [rip_const::BYTES-1:0]     we,
    input  logic [rip_const::ADDR_WIDTH-1:0] addr,
    input  rip_const::mem_word_u            wdata,
    output rip_const::mem_word_u            rdata,
    output logic                            done
);
    localparam int AW    = rip_const::ADDR_WIDTH;
    localparam int DW    = rip_const::DATA_WIDTH;
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CW    = $clog2(WAIT_STATES + 2);
    localparam logic [DW-1:0] INIT_PATTERN = 32'hc0de0000;

    rip_const::mem_word_u mem [MEM_WORDS];
    rip_const::mem_word_u merged;
    logic [IDX_W-1:0]     idx;
    logic [CW-1:0]        cnt;
    logic                 active;

    assign idx  = addr[IDX_W+1:2];
    assign done = active && (cnt == '0);

    // known contents at power up
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i].word = DW'(i) ^ INIT_PATTERN;
        end
    end

    always_comb begin
        merged = mem[idx];
        for (int b = 0; b < rip_const::BYTES; b++) begin
            if (we[b]) merged.bytes[b] = wdata.bytes[b];
        end
    end

    always_ff @(posedge clk) begin
        if (stb) begin
            rdata <= mem[idx];               // old word
            if (|we) mem[idx] <= merged;
        end
    end

    // ------------------------------------------------------------------------
    // done lands WAIT_STATES+1 cycles after stb
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (stb) begin
            active <= 1'b1;
            cnt    <= CW'(WAIT_STATES);
        end else if (active) begin
            if (cnt == '0) active <= 1'b0;
            else           cnt    <= cnt - 1'b1;
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rstn)
        stb |-> addr[AW-1:2] < MEM_WORDS)
        else $error("word index out of range");

endmodule

/* src/rip_const.sv */
package rip_const;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int ADDR_WIDTH = 32;           // byte address
    localparam int DATA_WIDTH = 32;
    localparam int B_WIDTH    = 8;
    localparam int BYTES      = DATA_WIDTH / B_WIDTH;

    // one memory word seen whole or as byte lanes
    typedef union packed {
        logic [DATA_WIDTH-1:0]           word;
        logic [BYTES-1:0][B_WIDTH-1:0]   bytes;
    } mem_word_u;

    // ------------------------------------------------------------------------
    // port request / response
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  re;   // read request, held until accepted
        logic [BYTES-1:0]      we;   // byte lane write enables
        logic [ADDR_WIDTH-1:0] addr;
        mem_word_u             din;
    } mem_req_s;

    typedef struct packed {
        logic      busy;
        mem_word_u dout;             // last read word of this port
    } mem_resp_s;

    // status seen outside the pseudo core
    typedef enum logic [1:0] {
        idle    = 2'b00,
        init    = 2'b01,
        reading = 2'b10,
        writing = 2'b11
    } core_status_e;

endpackage
